// File: Bender.yml
package:
  name: sha3_pad

sources:
  - logic/sha3_pad_pkg.sv
  - logic/pad_block_counter.sv
  - logic/pad_prefix_gen.sv
  - logic/pad_funcpad_merge.sv
  - logic/pad_ctrl_fsm.sv
  - logic/sha3_pad.sv
  - target: test
    files:
      - verification/tb_sha3_pad.sv

// File: logic/pad_block_counter.sv
// counts the words written into the current keccak block
// the count doubles as the write address and the prefix slice index

`timescale 1ns/10ps

module pad_block_counter (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  sha3_pad_pkg::keccak_strength_e          strength_i,
  input  logic                                    accept_i,
  input  logic                                    clear_i,
  output logic [sha3_pad_pkg::keccak_count_w-1:0] count_o,
  output logic                                    last_word_o,
  output logic                                    block_full_o
);

  logic [sha3_pad_pkg::keccak_count_w-1:0] limit;
  logic [sha3_pad_pkg::keccak_count_w-1:0] count_q;

  assign limit = sha3_pad_pkg::rate_words(strength_i);

  // clear wins over an accept in the same cycle, the word that ends a pad
  // block is accepted while the count is cleared for the next block
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (clear_i) begin
      count_q <= '0;
    end else if (accept_i) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign count_o = count_q;

  // the next accepted word is the last one of the block
  assign last_word_o  = ((count_q + 1'b1) == limit);
  assign block_full_o = (count_q == limit);

  // the control FSM must stop all writes once the block is full
  a_count_in_rate: assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q <= limit);

endmodule

// File: logic/pad_ctrl_fsm.sv
// padding control FSM, sequences prefix, message, pad and zero fill words
// it pulses run at each full block and absorbed after the final complete

`timescale 1ns/10ps

module pad_ctrl_fsm (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  sha3_pad_pkg::sha3_mode_e      mode_i,
  input  logic                          start_i,
  input  logic                          process_i,
  input  logic                          done_i,
  input  logic                          msg_valid_i,
  input  logic                          msg_partial_i,
  input  logic                          keccak_ack_i,
  input  logic                          keccak_complete_i,
  input  logic                          last_word_i,
  input  logic                          block_full_i,
  output sha3_pad_pkg::pad_src_e        src_o,
  output logic                          fsm_valid_o,
  output logic                          hold_msg_o,
  output logic                          clr_count_o,
  output logic                          load_buf_o,
  output logic                          clr_buf_o,
  output logic                          keccak_run_o,
  output logic                          absorbed_o
);

  typedef enum logic [3:0] {
    st_idle,
    st_prefix,
    st_prefix_wait,
    st_message,
    st_message_wait,
    st_pad,
    st_pad_run,
    st_pad01,
    st_pad_flush
  } pad_st_e;

  pad_st_e st_q, st_d;
  logic    process_q;
  logic    absorbed_d;

  //////////////////////////////////////////////////
  // process latch
  //////////////////////////////////////////////////

  // process may come while the prefix is still going out, so it is held
  // until the message state can act on it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      process_q <= 1'b0;
    end else if (process_i) begin
      process_q <= 1'b1;
    end else if (done_i) begin
      process_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      st_q       <= st_idle;
      absorbed_o <= 1'b0;
    end else begin
      st_q       <= st_d;
      absorbed_o <= absorbed_d;
    end
  end

  //////////////////////////////////////////////////
  // next state and outputs
  //////////////////////////////////////////////////

  always_comb begin
    st_d         = st_q;
    src_o        = sha3_pad_pkg::src_none;
    fsm_valid_o  = 1'b0;
    hold_msg_o   = 1'b0;
    clr_count_o  = 1'b0;
    load_buf_o   = 1'b0;
    clr_buf_o    = 1'b0;
    keccak_run_o = 1'b0;
    absorbed_d   = 1'b0;

    unique case (st_q)
      st_idle: begin
        // every hash starts at word 0 of a fresh block
        clr_count_o = 1'b1;
        if (start_i) begin
          st_d = (mode_i == sha3_pad_pkg::cshake) ? st_prefix : st_message;
        end
      end

      // prefix words are sent up to the block end, the slicer zero fills
      st_prefix: begin
        src_o = sha3_pad_pkg::src_prefix;
        if (block_full_i) begin
          st_d         = st_prefix_wait;
          keccak_run_o = 1'b1;
          clr_count_o  = 1'b1;
        end else begin
          fsm_valid_o = 1'b1;
        end
      end

      st_prefix_wait: begin
        src_o = sha3_pad_pkg::src_prefix;
        if (keccak_complete_i) begin
          st_d = st_message;
        end
      end

      // full beats go straight through, a partial beat goes to the buffer
      st_message: begin
        src_o = sha3_pad_pkg::src_msg;
        if (msg_valid_i && msg_partial_i) begin
          load_buf_o = 1'b1;
        end else if (block_full_i) begin
          // a full block runs before padding even if process is already set
          st_d         = st_message_wait;
          keccak_run_o = 1'b1;
          clr_count_o  = 1'b1;
          hold_msg_o   = 1'b1;
        end else if (process_q && !msg_valid_i) begin
          // the message ends once process is latched and no beat is left
          st_d       = st_pad;
          hold_msg_o = 1'b1;
        end
      end

      st_message_wait: begin
        hold_msg_o = 1'b1;
        if (keccak_complete_i) begin
          st_d = st_message;
        end
      end

      // one word with the buffered bytes and the suffix
      st_pad: begin
        src_o       = sha3_pad_pkg::src_funcpad;
        fsm_valid_o = 1'b1;
        if (keccak_ack_i && last_word_i) begin
          // the end bit went out in the same word, no zero fill is needed
          st_d        = st_pad_run;
          clr_buf_o   = 1'b1;
          clr_count_o = 1'b1;
        end else if (keccak_ack_i) begin
          st_d      = st_pad01;
          clr_buf_o = 1'b1;
        end
      end

      st_pad_run: begin
        st_d         = st_pad_flush;
        keccak_run_o = 1'b1;
        clr_count_o  = 1'b1;
      end

      // zero words to the block end, the last one carries bit 63
      st_pad01: begin
        src_o = sha3_pad_pkg::src_zero_end;
        if (block_full_i) begin
          st_d         = st_pad_flush;
          keccak_run_o = 1'b1;
          clr_count_o  = 1'b1;
        end else begin
          fsm_valid_o = 1'b1;
        end
      end

      // wait for the final permutation, then report the sponge absorbed
      st_pad_flush: begin
        clr_count_o = 1'b1;
        clr_buf_o   = 1'b1;
        if (keccak_complete_i) begin
          st_d       = st_idle;
          absorbed_d = 1'b1;
        end
      end

      default: begin
        st_d = st_idle;
      end
    endcase
  end

  // once a block is handed to the round, nothing is written until it completes
  a_no_valid_in_wait: assert property (@(posedge clk_i) disable iff (!rst_ni)
    keccak_run_o |=> (!fsm_valid_o until keccak_complete_i));

endmodule

// File: logic/pad_funcpad_merge.sv
// holds the partial last beat of a message and merges it with the padding
// the merged word carries the buffered bytes, the function suffix with the
// first pad10*1 bit, and the end bit when it is the last word of the block

`timescale 1ns/10ps

module pad_funcpad_merge (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  sha3_pad_pkg::msg_beat_t            msg_i,
  input  logic                               load_i,
  input  logic                               clear_i,
  input  sha3_pad_pkg::sha3_mode_e           mode_i,
  input  logic                               last_word_i,
  output logic [sha3_pad_pkg::msg_width-1:0] pad_word_o
);

  //////////////////////////////////////////////////
  // partial beat buffer
  //////////////////////////////////////////////////

  // a partial beat never has byte 7, so seven bytes are enough
  logic [sha3_pad_pkg::msg_width-9:0]  buf_q;
  logic [sha3_pad_pkg::msg_strb_w-2:0] strb_q;

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      buf_q <= msg_i.data[sha3_pad_pkg::msg_width-9:0];
    end
  end

  // only the strobe has to be cleared, it masks every buffered byte
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      strb_q <= '0;
    end else if (load_i) begin
      strb_q <= msg_i.strb[sha3_pad_pkg::msg_strb_w-2:0];
    end else if (clear_i) begin
      strb_q <= '0;
    end
  end

  //////////////////////////////////////////////////
  // function suffix and merge
  //////////////////////////////////////////////////

  // domain bits followed by the leading 1 of pad10*1, lsb first
  logic [4:0] suffix;

  always_comb begin
    case (mode_i)
      sha3_pad_pkg::sha3:   suffix = 5'b00110;
      sha3_pad_pkg::shake:  suffix = 5'b11111;
      sha3_pad_pkg::cshake: suffix = 5'b00100;
      // bare pad10*1 for an unknown mode
      default:              suffix = 5'b00001;
    endcase
  end

  always_comb begin
    int unsigned nbytes;
    nbytes     = 0;
    pad_word_o = '0;
    // the strobe is contiguous from byte 0 so the count is the byte offset
    for (int i = 0; i < sha3_pad_pkg::msg_strb_w - 1; i++) begin
      if (strb_q[i]) begin
        pad_word_o[8*i +: 8] = buf_q[8*i +: 8];
        nbytes = nbytes + 1;
      end
    end
    pad_word_o = pad_word_o | (sha3_pad_pkg::msg_width'(suffix) << (8 * nbytes));
    // bit 63 is free even with seven buffered bytes, the suffix ends at bit 60
    pad_word_o[sha3_pad_pkg::msg_width-1] = last_word_i;
  end

  // the source only sends a partial beat with bytes packed from byte 0
  a_strb_contig: assert property (@(posedge clk_i) disable iff (!rst_ni)
    load_i |-> ((msg_i.strb & (msg_i.strb + 1'b1)) == '0));

endmodule

// File: logic/pad_prefix_gen.sv
// builds the cSHAKE bytepad prefix and returns one 64 bit slice of it
// byte 0 is 0x01, byte 1 the rate in bytes, then the encoded N and S bytes

`timescale 1ns/10ps

module pad_prefix_gen #(
  parameter int ns_bytes = 22
) (
  input  sha3_pad_pkg::keccak_strength_e          strength_i,
  input  logic [ns_bytes*8-1:0]                   ns_data_i,
  input  logic [sha3_pad_pkg::keccak_count_w-1:0] index_i,
  output logic [sha3_pad_pkg::msg_width-1:0]      word_o
);

  // prefix length rounded up to whole words so every slice is in range
  localparam int prefix_w     = (ns_bytes + 2) * 8;
  localparam int prefix_words = (prefix_w + sha3_pad_pkg::msg_width - 1) /
                                sha3_pad_pkg::msg_width;
  localparam int padded_w     = prefix_words * sha3_pad_pkg::msg_width;

  logic [prefix_w-1:0] prefix;
  logic [padded_w-1:0] prefix_ext;

  // left_encode of the rate is the byte count 0x01 followed by the rate
  assign prefix     = {ns_data_i, sha3_pad_pkg::rate_bytes(strength_i), 8'h01};
  assign prefix_ext = padded_w'(prefix);

  // words past the end of the prefix are the bytepad zero fill
  always_comb begin
    word_o = '0;
    if (index_i < prefix_words) begin
      word_o = prefix_ext[index_i*sha3_pad_pkg::msg_width +: sha3_pad_pkg::msg_width];
    end
  end

endmodule

// File: logic/sha3_pad.sv
// top level of the SHA-3 padding front end
// takes message beats, writes prefix, message and pad words into the keccak
// state and drives run and absorbed, ns_bytes sets the encoded N and S width

`timescale 1ns/10ps

module sha3_pad #(
  parameter int ns_bytes = 22
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  sha3_pad_pkg::pad_cfg_t  cfg_i,
  input  logic [ns_bytes*8-1:0]   ns_data_i,
  input  logic                    msg_valid_i,
  input  sha3_pad_pkg::msg_beat_t msg_i,
  output logic                    msg_ready_o,
  output logic                    keccak_valid_o,
  output sha3_pad_pkg::keccak_wr_t keccak_wr_o,
  input  logic                    keccak_ready_i,
  output logic                    keccak_run_o,
  input  logic                    keccak_complete_i,
  input  logic                    start_i,
  input  logic                    process_i,
  input  logic                    done_i,
  output logic                    absorbed_o
);

  sha3_pad_pkg::pad_src_e                  src;
  logic                                    fsm_valid;
  logic                                    hold_msg;
  logic                                    clr_count;
  logic                                    load_buf;
  logic                                    clr_buf;
  logic [sha3_pad_pkg::keccak_count_w-1:0] count;
  logic                                    last_word;
  logic                                    block_full;
  logic [sha3_pad_pkg::msg_width-1:0]      prefix_word;
  logic [sha3_pad_pkg::msg_width-1:0]      pad_word;
  logic                                    keccak_ack;
  logic                                    msg_partial;

  assign keccak_ack  = keccak_valid_o & keccak_ready_i;
  // any missing byte marks the last, partial beat of the message
  assign msg_partial = ~&msg_i.strb;

  pad_ctrl_fsm u_ctrl (
    .clk_i, .rst_ni,
    .mode_i (cfg_i.mode),
    .start_i, .process_i, .done_i, .msg_valid_i,
    .msg_partial_i (msg_partial),
    .keccak_ack_i  (keccak_ack),
    .keccak_complete_i,
    .last_word_i   (last_word),
    .block_full_i  (block_full),
    .src_o         (src),
    .fsm_valid_o   (fsm_valid),
    .hold_msg_o    (hold_msg),
    .clr_count_o   (clr_count),
    .load_buf_o    (load_buf),
    .clr_buf_o     (clr_buf),
    .keccak_run_o, .absorbed_o
  );

  pad_block_counter u_count (
    .clk_i, .rst_ni,
    .strength_i   (cfg_i.strength),
    .accept_i     (keccak_ack),
    .clear_i      (clr_count),
    .count_o      (count),
    .last_word_o  (last_word),
    .block_full_o (block_full)
  );

  pad_prefix_gen #(.ns_bytes(ns_bytes)) u_prefix (
    .strength_i (cfg_i.strength),
    .ns_data_i,
    .index_i    (count),
    .word_o     (prefix_word)
  );

  pad_funcpad_merge u_merge (
    .clk_i, .rst_ni, .msg_i,
    .load_i      (load_buf),
    .clear_i     (clr_buf),
    .mode_i      (cfg_i.mode),
    .last_word_i (last_word),
    .pad_word_o  (pad_word)
  );

  //////////////////////////////////////////////////
  // output mux
  //////////////////////////////////////////////////

  // message beats bypass the FSM valid, a held or buffered beat is not written
  always_comb begin
    keccak_wr_o.addr = count;
    keccak_wr_o.data = '0;
    keccak_valid_o   = 1'b0;
    msg_ready_o      = 1'b0;
    unique case (src)
      sha3_pad_pkg::src_msg: begin
        keccak_wr_o.data = msg_i.data;
        keccak_valid_o   = msg_valid_i & ~hold_msg & ~load_buf;
        msg_ready_o      = load_buf | (keccak_ready_i & ~hold_msg);
      end
      sha3_pad_pkg::src_prefix: begin
        keccak_wr_o.data = prefix_word;
        keccak_valid_o   = fsm_valid;
      end
      sha3_pad_pkg::src_funcpad: begin
        keccak_wr_o.data = pad_word;
        keccak_valid_o   = fsm_valid;
      end
      sha3_pad_pkg::src_zero_end: begin
        keccak_wr_o.data = {last_word, {(sha3_pad_pkg::msg_width-1){1'b0}}};
        keccak_valid_o   = fsm_valid;
      end
      default: begin
        keccak_valid_o = 1'b0;
      end
    endcase
  end

endmodule

// File: logic/sha3_pad_pkg.sv
// shared widths, enums and structs for the SHA-3 padding front end
// modules refer to these by scoped name, the rate tables are plain functions

package sha3_pad_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  // one message beat and one keccak state word are the same width
  localparam int msg_width      = 64;
  localparam int msg_strb_w     = msg_width / 8;
  // 25 lanes of 64 bits in the 1600 bit state
  localparam int keccak_addr_w  = 5;
  localparam int keccak_count_w = 5;

  //////////////////////////////////////////////////
  // enums
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    sha3,
    shake,
    cshake
  } sha3_mode_e;

  typedef enum logic [2:0] {
    l128,
    l224,
    l256,
    l384,
    l512
  } keccak_strength_e;

  // source of the word driven onto the keccak write port
  typedef enum logic [2:0] {
    src_none,
    src_msg,
    src_prefix,
    src_funcpad,
    src_zero_end
  } pad_src_e;

  //////////////////////////////////////////////////
  // structs
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [msg_width-1:0]  data;
    logic [msg_strb_w-1:0] strb;
  } msg_beat_t;

  typedef struct packed {
    logic [keccak_addr_w-1:0] addr;
    logic [msg_width-1:0]     data;
  } keccak_wr_t;

  typedef struct packed {
    sha3_mode_e       mode;
    keccak_strength_e strength;
  } pad_cfg_t;

  // block size in 64 bit words, the rate is 1600 minus twice the strength
  function automatic logic [keccak_count_w-1:0] rate_words(keccak_strength_e strength);
    case (strength)
      l128:    return keccak_count_w'(21);
      l224:    return keccak_count_w'(18);
      l256:    return keccak_count_w'(17);
      l384:    return keccak_count_w'(13);
      l512:    return keccak_count_w'(9);
      default: return '0;
    endcase
  endfunction

  // same block size in bytes, used as the encoded rate in the cSHAKE prefix
  function automatic logic [7:0] rate_bytes(keccak_strength_e strength);
    case (strength)
      l128:    return 8'd168;
      l224:    return 8'd144;
      l256:    return 8'd136;
      l384:    return 8'd104;
      l512:    return 8'd72;
      default: return 8'd0;
    endcase
  endfunction

endpackage

// File: src.f
logic/sha3_pad_pkg.sv
logic/pad_block_counter.sv
logic/pad_prefix_gen.sv
logic/pad_funcpad_merge.sv
logic/pad_ctrl_fsm.sv
logic/sha3_pad.sv
verification/tb_sha3_pad.sv

// File: verification/sha3_pad_trace.txt
# fields in hex, mode 0 sha3 1 shake 2 cshake, strength 0 l128 1 l224 2 l256 3 l384 4 l512
# T mode strength backpressure runs | N ns_data | M strb data addr | E addr data | Z first last endbit | G
# SHA3-256, full beats, pad word 0x06, zero fill, end bit at word 16
T 0 2 0 1
M ff 0123456789abcdef 0
M ff fedcba9876543210 1
M ff 0f1e2d3c4b5a6978 2
E 3 0000000000000006
Z 4 10 1
G
# SHAKE128, last beat with 3 bytes, suffix 0x1f in byte 3, end bit at word 20
T 1 0 0 1
M ff 1122334455667788 0
M 07 deadbeef99c0ffee 0
E 1 000000001fc0ffee
Z 2 14 1
G
# cSHAKE256, bytepad prefix block, then the message from address 0
T 2 2 1 2
N 21646e6520746e6f726620676e696464617090010001
E 0 6170900100018801
E 1 726620676e696464
E 2 21646e6520746e6f
Z 3 10 0
M ff 0706050403020100 0
E 1 0000000000000004
Z 2 10 1
G
# SHA3-512, message ends one word before the block end
T 0 4 0 1
M ff 0000000000000000 0
M ff ffffffffffffffff 1
M ff 8000000000000001 2
M ff 7ffffffffffffffe 3
M ff 5555555555555555 4
M ff aaaaaaaaaaaaaaaa 5
M ff 0123012301230123 6
M ff c3c3c3c3c3c3c3c3 7
E 8 8000000000000006
G
# SHA3-224 under back-pressure, last beat with 5 bytes
T 0 1 1 1
M ff 0001020304050607 0
M ff 08090a0b0c0d0e0f 1
M 1f ffffff1413121110 0
E 2 0000061413121110
Z 3 11 1
G

// File: verification/tb_sha3_pad.sv
// testbench for the SHA-3 padding front end
// replays the trace file, models the keccak round with random back-pressure
// and checks every write into the keccak state against the trace

`timescale 1ns/10ps

module tb_sha3_pad;

  localparam int ns_bytes = 22;

  // one parsed trace line, the meaning of a to d depends on the command
  typedef struct packed {
    logic [7:0]  cmd;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] c;
    logic [63:0] d;
  } rec_t;

  logic                     clk_i;
  logic                     rst_ni;
  sha3_pad_pkg::pad_cfg_t   cfg_i;
  logic [ns_bytes*8-1:0]    ns_data_i;
  logic                     msg_valid_i;
  sha3_pad_pkg::msg_beat_t  msg_i;
  logic                     msg_ready_o;
  logic                     keccak_valid_o;
  sha3_pad_pkg::keccak_wr_t keccak_wr_o;
  logic                     keccak_ready_i;
  logic                     keccak_run_o;
  logic                     keccak_complete_i;
  logic                     start_i;
  logic                     process_i;
  logic                     done_i;
  logic                     absorbed_o;

  rec_t                     recs[$];
  logic [ns_bytes*8-1:0]    ns_q[$];
  sha3_pad_pkg::msg_beat_t  beats[$];
  logic [63:0]              exp_addr[$];
  logic [63:0]              exp_data[$];

  logic bp_on;
  int   errors;
  int   checks;
  int   runs_seen;
  int   absorbed_seen;
  int   cycle_cnt;
  int   cycle_limit;
  int   test_no;

  sha3_pad #(.ns_bytes(ns_bytes)) u_dut (
    .clk_i, .rst_ni, .cfg_i, .ns_data_i,
    .msg_valid_i, .msg_i, .msg_ready_o,
    .keccak_valid_o, .keccak_wr_o, .keccak_ready_i,
    .keccak_run_o, .keccak_complete_i,
    .start_i, .process_i, .done_i, .absorbed_o
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // checks and monitors
  //////////////////////////////////////////////////

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: test %0d %s got 0x%h expected 0x%h", test_no, name, got, exp);
    end
  endtask

  task automatic push_expected(input logic [63:0] addr, input logic [63:0] data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  // every accepted write must be the next one in the expected list
  always @(posedge clk_i) begin
    if (rst_ni && keccak_valid_o && keccak_ready_i) begin
      if (exp_addr.size() == 0) begin
        errors++;
        $display("test %0d wrote 0x%h at address %0d when no write was expected",
                 test_no, keccak_wr_o.data, keccak_wr_o.addr);
      end else begin
        compare_value("keccak_wr_o.addr", 64'(keccak_wr_o.addr), exp_addr.pop_front());
        compare_value("keccak_wr_o.data", keccak_wr_o.data, exp_data.pop_front());
      end
    end
    if (rst_ni && keccak_run_o) begin
      runs_seen++;
    end
    if (rst_ni && absorbed_o) begin
      absorbed_seen++;
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      $display("timeout, the run did not finish within %0d cycles", cycle_limit);
      $display("checks %0d errors %0d", checks, errors);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // keccak model
  //////////////////////////////////////////////////

  // ready drops on about one cycle in four while back-pressure is on
  always @(posedge clk_i) begin
    keccak_ready_i <= bp_on ? (($urandom % 4) != 0) : 1'b1;
  end

  // the round answers each run with complete 2 to 5 cycles later
  initial begin
    int unsigned delay;
    forever begin
      @(posedge clk_i);
      if (rst_ni && keccak_run_o) begin
        delay = 2 + ($urandom % 4);
        repeat (delay - 1) @(posedge clk_i);
        keccak_complete_i <= 1'b1;
        @(posedge clk_i);
        keccak_complete_i <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // trace replay
  //////////////////////////////////////////////////

  task automatic load_trace(input int fd, output int total);
    logic [7:0]            cmd;
    logic [8*256-1:0]      rest;
    logic [ns_bytes*8-1:0] ns;
    logic [63:0]           a;
    logic [63:0]           b;
    logic [63:0]           c;
    logic [63:0]           d;
    int                    n;
    bit                    more;
    more  = 1'b1;
    total = 0;
    while (more) begin
      a = '0;
      b = '0;
      c = '0;
      d = '0;
      n = $fscanf(fd, " %c", cmd);
      if (n != 1) begin
        more = 1'b0;
      end else begin
        case (cmd)
          "#": n = $fgets(rest, fd);
          "N": begin
            n = $fscanf(fd, "%h", ns);
            ns_q.push_back(ns);
          end
          "T": n = $fscanf(fd, "%h %h %h %h", a, b, c, d);
          "M", "Z": n = $fscanf(fd, "%h %h %h", a, b, c);
          "E": n = $fscanf(fd, "%h %h", a, b);
          "G": n = 0;
          default: begin
            errors++;
            $display("trace holds an unknown command %c", cmd);
          end
        endcase
        if (cmd != "#") begin
          recs.push_back({cmd, a, b, c, d});
        end
        // a full beat, an E line and each zero word are one write each
        if (cmd == "E" || (cmd == "M" && a[7:0] == 8'hff)) begin
          total++;
        end else if (cmd == "Z") begin
          total += int'(b - a) + 1;
        end
      end
    end
  endtask

  task automatic run_test(input sha3_pad_pkg::pad_cfg_t cfg,
                          input logic [ns_bytes*8-1:0] ns,
                          input logic [63:0] exp_runs);
    sha3_pad_pkg::msg_beat_t beat;
    bit                      early;
    runs_seen     = 0;
    absorbed_seen = 0;
    // in cSHAKE mode process comes while the prefix block is still going out
    early         = (cfg.mode == sha3_pad_pkg::cshake);
    @(posedge clk_i);
    cfg_i     <= cfg;
    ns_data_i <= ns;
    start_i   <= 1'b1;
    @(posedge clk_i);
    start_i <= 1'b0;
    if (early) begin
      process_i <= 1'b1;
      @(posedge clk_i);
      process_i <= 1'b0;
    end
    // each beat stays on the bus until the handshake takes it
    while (beats.size() > 0) begin
      beat = beats.pop_front();
      msg_valid_i <= 1'b1;
      msg_i       <= beat;
      @(posedge clk_i);
      while (!msg_ready_o) @(posedge clk_i);
    end
    msg_valid_i <= 1'b0;
    if (!early) begin
      process_i <= 1'b1;
      @(posedge clk_i);
      process_i <= 1'b0;
    end
    while (!absorbed_o) @(posedge clk_i);
    done_i <= 1'b1;
    @(posedge clk_i);
    done_i <= 1'b0;
    compare_value("keccak_run_o pulses", 64'(runs_seen), exp_runs);
    compare_value("absorbed_o pulses", 64'(absorbed_seen), 64'd1);
    if (exp_addr.size() != 0) begin
      errors++;
      $display("test %0d ended with %0d expected writes never made",
               test_no, exp_addr.size());
      exp_addr.delete();
      exp_data.delete();
    end
  endtask

  task automatic replay_trace();
    sha3_pad_pkg::pad_cfg_t  cfg;
    sha3_pad_pkg::msg_beat_t beat;
    logic [ns_bytes*8-1:0]   ns;
    logic [63:0]             exp_runs;
    logic [63:0]             i;
    rec_t                    r;
    cfg      = '0;
    ns       = '0;
    exp_runs = '0;
    for (int k = 0; k < recs.size(); k++) begin
      r = recs[k];
      case (r.cmd)
        "T": begin
          test_no++;
          cfg.mode     = sha3_pad_pkg::sha3_mode_e'(r.a[1:0]);
          cfg.strength = sha3_pad_pkg::keccak_strength_e'(r.b[2:0]);
          bp_on       <= r.c[0];
          exp_runs     = r.d;
          $display("test %0d mode %0d strength %0d back-pressure %0d",
                   test_no, r.a, r.b, r.c[0]);
        end
        "N": ns = ns_q.pop_front();
        "M": begin
          beat.data = r.b;
          beat.strb = r.a[7:0];
          beats.push_back(beat);
          // a full beat is written unchanged at the address it names
          if (&beat.strb) begin
            push_expected(r.c, r.b);
          end
        end
        "E": push_expected(r.a, r.b);
        "Z": begin
          for (i = r.a; i <= r.b; i++) begin
            push_expected(i, (i == r.b && r.c[0]) ? {1'b1, 63'd0} : 64'd0);
          end
        end
        "G": run_test(cfg, ns, exp_runs);
        default: ;
      endcase
    end
  endtask

  initial begin
    int fd;
    int total;
    rst_ni            <= 1'b0;
    cfg_i             <= '0;
    ns_data_i         <= '0;
    msg_valid_i       <= 1'b0;
    msg_i             <= '0;
    keccak_ready_i    <= 1'b0;
    keccak_complete_i <= 1'b0;
    start_i           <= 1'b0;
    process_i         <= 1'b0;
    done_i            <= 1'b0;
    bp_on             <= 1'b0;
    errors      = 0;
    checks      = 0;
    cycle_cnt   = 0;
    cycle_limit = 0;
    test_no     = 0;
    void'($urandom(32'h9e9b3af8));
    fd = $fopen("verification/sha3_pad_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open the trace file verification/sha3_pad_trace.txt");
      $display("RESULT: FAIL");
      $finish;
    end else begin
      load_trace(fd, total);
      $fclose(fd);
      cycle_limit = 40 * total + 200;
      repeat (4) @(posedge clk_i);
      rst_ni <= 1'b1;
      @(posedge clk_i);
      compare_value("keccak_valid_o", 64'(keccak_valid_o), 64'd0);
      compare_value("msg_ready_o", 64'(msg_ready_o), 64'd0);
      compare_value("keccak_run_o", 64'(keccak_run_o), 64'd0);
      compare_value("absorbed_o", 64'(absorbed_o), 64'd0);
      replay_trace();
      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0) begin
        $display("RESULT: PASS");
      end else begin
        $display("RESULT: FAIL");
      end
      $finish;
    end
  end

endmodule
